// ==== tagPkg.sv ====
// shared widths and formats; 8 registers, tags 1..15 with 0 meaning free, at most three in flight
package tagPkg;

    localparam int dataW = 16;
    localparam int nameW = 3;
    localparam int tagW = 4;
    localparam int memAddrW = 8;

    // a register whose tag is free holds valid data
    localparam logic [tagW-1:0] tagFree = '0;

    typedef enum logic [1:0] {
        opAlu   = 2'd0,
        opLoad  = 2'd1,
        opStore = 2'd2
    } opKind;

    // shl shifts operand A left by the low 4 bits of operand B
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluShl = 3'd5
    } aluFunc;

    typedef struct packed {
        logic [1:0]       pad;
        logic [nameW-1:0] dest;
        logic [nameW-1:0] srcA;
        logic [nameW-1:0] srcB;
        aluFunc           func;
    } aluFields;

    // dataReg is the load destination or the store data source
    typedef struct packed {
        logic [nameW-1:0]    dataReg;
        logic [nameW-1:0]    base;
        logic [memAddrW-1:0] offset;
    } memFields;

    // one 14-bit word, decoded by the instruction kind
    typedef union packed {
        aluFields alu;
        memFields mem;
    } instrPayload;

    typedef struct packed {
        opKind       kind;
        instrPayload payload;
    } instr;

    typedef struct packed {
        logic                valid;
        logic [tagW-1:0]     tag;
        logic [nameW-1:0]    dest;
        opKind               kind;
        aluFunc              func;
        logic [dataW-1:0]    opA;
        logic [dataW-1:0]    opB;
        logic [memAddrW-1:0] offset;
    } issueBundle;

    typedef struct packed {
        logic             valid;
        logic [nameW-1:0] name;
        logic [tagW-1:0]  tag;
        logic [dataW-1:0] data;
    } wbBundle;

endpackage

// ==== dispatchUnit.sv ====
// issues one instruction per cycle at most; an instruction waits here until its sources are free
module dispatchUnit (
    input  logic                      clk,
    input  logic                      arstN,
    input  tagPkg::instr              instIn,
    input  logic                      instValid,
    output logic                      instReady,
    output logic [tagPkg::nameW-1:0]  nameA,
    output logic [tagPkg::nameW-1:0]  nameB,
    input  logic [tagPkg::dataW-1:0]  dataA,
    input  logic [tagPkg::dataW-1:0]  dataB,
    input  logic [tagPkg::tagW-1:0]   tagA,
    input  logic [tagPkg::tagW-1:0]   tagB,
    output logic                      decWrtEn,
    output logic [tagPkg::nameW-1:0]  decWrtName,
    output logic [tagPkg::tagW-1:0]   decWrtTag,
    output tagPkg::issueBundle        aluIssue,
    output tagPkg::issueBundle        lsIssue
);
    import tagPkg::*;

    logic [nameW-1:0] dest;
    logic             needB;
    logic             toLs;
    logic             accept;
    logic [tagW-1:0]  tagNext;
    logic [nameW-1:0] pendDest;
    issueBundle       issueNext;

    // pick source and destination names by format
    always_comb begin
        case (instIn.kind)
            opLoad: begin
                nameA = instIn.payload.mem.base;
                nameB = instIn.payload.mem.dataReg;
                dest  = instIn.payload.mem.dataReg;
                needB = 1'b0;
            end
            opStore: begin
                nameA = instIn.payload.mem.base;
                nameB = instIn.payload.mem.dataReg;
                dest  = instIn.payload.mem.dataReg;
                needB = 1'b1;
            end
            default: begin
                nameA = instIn.payload.alu.srcA;
                nameB = instIn.payload.alu.srcB;
                dest  = instIn.payload.alu.dest;
                needB = 1'b1;
            end
        endcase
    end

    assign toLs = (instIn.kind == opLoad) || (instIn.kind == opStore);
    assign instReady = (tagA == tagFree) && (!needB || tagB == tagFree);
    assign accept = instValid && instReady;

    // stores leave the register tags alone
    assign decWrtEn = accept && (instIn.kind != opStore);
    assign decWrtName = dest;
    assign decWrtTag = tagNext;

    // destination of the instruction issued last cycle
    assign pendDest = aluIssue.valid ? aluIssue.dest : lsIssue.dest;

    always_comb begin
        issueNext.valid  = accept;
        issueNext.tag    = tagNext;
        issueNext.dest   = dest;
        issueNext.kind   = instIn.kind;
        issueNext.func   = instIn.payload.alu.func;
        issueNext.opA    = dataA;
        issueNext.opB    = dataB;
        issueNext.offset = instIn.payload.mem.offset;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tagNext  <= tagW'(1);
            aluIssue <= '0;
            lsIssue  <= '0;
        end else begin
            // tags run 1..15 and never hand out the free value
            if (accept) begin
                tagNext <= (tagNext == '1) ? tagW'(1) : tagNext + tagW'(1);
            end
            aluIssue       <= issueNext;
            aluIssue.valid <= issueNext.valid && !toLs;
            lsIssue        <= issueNext;
            lsIssue.valid  <= issueNext.valid && toLs;
        end
    end

    aIssuedTagNotFree: assert property (@(posedge clk) disable iff (!arstN)
        accept |=> (aluIssue.valid ? aluIssue.tag : lsIssue.tag) != tagFree)
        else $error("dispatch issued the free tag");

    // a result issued last cycle has not come back yet, so its register is still busy
    aNoBusyAccept: assert property (@(posedge clk) disable iff (!arstN)
        (accept && (aluIssue.valid || (lsIssue.valid && lsIssue.kind == opLoad))) |->
            (nameA != pendDest) && (instIn.kind == opLoad || nameB != pendDest))
        else $error("dispatch accepted with a busy source");

endmodule

// ==== aluUnit.sv ====
// fully pipelined, one result per cycle; undefined function codes give zero
module aluUnit (
    input  logic               clk,
    input  logic               arstN,
    input  tagPkg::issueBundle aluIssue,
    output tagPkg::wbBundle    aluWb
);
    import tagPkg::*;

    logic [dataW-1:0] result;

    always_comb begin
        case (aluIssue.func)
            aluAdd: begin
                result = aluIssue.opA + aluIssue.opB;
            end
            aluSub: begin
                result = aluIssue.opA - aluIssue.opB;
            end
            aluAnd: begin
                result = aluIssue.opA & aluIssue.opB;
            end
            aluOr: begin
                result = aluIssue.opA | aluIssue.opB;
            end
            aluXor: begin
                result = aluIssue.opA ^ aluIssue.opB;
            end
            aluShl: begin
                // only the low 4 bits count as shift amount
                result = aluIssue.opA << aluIssue.opB[3:0];
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // result leaves with its tag so the register file can match it
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            aluWb <= '0;
        end else begin
            aluWb.valid <= aluIssue.valid;
            aluWb.name  <= aluIssue.dest;
            aluWb.tag   <= aluIssue.tag;
            aluWb.data  <= result;
        end
    end

endmodule

// ==== loadStoreUnit.sv ====
// in-order two-stage pipeline; memDepth must not exceed 2**memAddrW, memory starts zeroed
module loadStoreUnit #(
    parameter int memDepth = 256
) (
    input  logic               clk,
    input  logic               arstN,
    input  tagPkg::issueBundle lsIssue,
    output tagPkg::wbBundle    lsWb
);
    import tagPkg::*;

    logic [dataW-1:0]    mem [memDepth];
    logic [memAddrW-1:0] addr;
    logic                isStore;
    logic                isLoad;

    // stage 1 state
    logic                s1Valid;
    logic [nameW-1:0]    s1Name;
    logic [tagW-1:0]     s1Tag;
    logic [dataW-1:0]    s1Data;

    // base plus offset wraps at the memory size
    assign addr = memAddrW'((lsIssue.opA + dataW'(lsIssue.offset)) % memDepth);
    assign isStore = lsIssue.valid && (lsIssue.kind == opStore);
    assign isLoad = lsIssue.valid && (lsIssue.kind == opLoad);

    // block RAM contents start at zero
    initial begin
        for (int i = 0; i < memDepth; i++) begin
            mem[i] = '0;
        end
    end

    // store writes and load reads share the stage 1 edge
    always_ff @(posedge clk) begin
        if (isStore) begin
            mem[addr] <= lsIssue.opB;
        end
        s1Data <= mem[addr];
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s1Valid <= 1'b0;
            s1Name  <= '0;
            s1Tag   <= tagFree;
            lsWb    <= '0;
        end else begin
            s1Valid <= isLoad;
            s1Name  <= lsIssue.dest;
            s1Tag   <= lsIssue.tag;
            // stage 2 presents the loaded word
            lsWb.valid <= s1Valid;
            lsWb.name  <= s1Name;
            lsWb.tag   <= s1Tag;
            lsWb.data  <= s1Data;
        end
    end

    aNoAluOnLs: assert property (@(posedge clk) disable iff (!arstN)
        lsIssue.valid |-> lsIssue.kind != opAlu)
        else $error("ALU instruction routed to load/store unit");

endmodule

// ==== tagRegfile.sv ====
// numRegs must equal 2**nameW; a writeback lands only while its tag is still the register's tag
module tagRegfile #(
    parameter int numRegs = 8
) (
    input  logic                     clk,
    input  logic                     arstN,
    input  tagPkg::wbBundle          aluWb,
    input  tagPkg::wbBundle          lsWb,
    input  logic [tagPkg::nameW-1:0] nameA,
    input  logic [tagPkg::nameW-1:0] nameB,
    output logic [tagPkg::dataW-1:0] dataA,
    output logic [tagPkg::dataW-1:0] dataB,
    output logic [tagPkg::tagW-1:0]  tagA,
    output logic [tagPkg::tagW-1:0]  tagB,
    input  logic                     decWrtEn,
    input  logic [tagPkg::nameW-1:0] decWrtName,
    input  logic [tagPkg::tagW-1:0]  decWrtTag,
    input  logic [tagPkg::nameW-1:0] rdName,
    output logic [tagPkg::dataW-1:0] rdData,
    output logic                     rdBusy
);
    import tagPkg::*;

    logic [dataW-1:0] dataR [numRegs];
    logic [tagW-1:0]  tagR  [numRegs];
    logic [tagW-1:0]  rdTag;

    // read with bypass of a matching writeback in the same cycle
    function automatic logic [dataW+tagW-1:0] readPort(input logic [nameW-1:0] n);
        if (aluWb.valid && aluWb.name == n && aluWb.tag == tagR[n]) begin
            return {aluWb.data, tagFree};
        end
        if (lsWb.valid && lsWb.name == n && lsWb.tag == tagR[n]) begin
            return {lsWb.data, tagFree};
        end
        return {dataR[n], tagR[n]};
    endfunction

    always_comb begin
        {dataA, tagA} = readPort(nameA);
        {dataB, tagB} = readPort(nameB);
        {rdData, rdTag} = readPort(rdName);
    end

    assign rdBusy = (rdTag != tagFree);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                dataR[i] <= '0;
                tagR[i]  <= tagFree;
            end
        end else begin
            for (int i = 0; i < numRegs; i++) begin
                // a new dispatch tag overrides any writeback to the same register
                if (decWrtEn && decWrtName == nameW'(i)) begin
                    tagR[i] <= decWrtTag;
                end else if (aluWb.valid && aluWb.name == nameW'(i)
                             && aluWb.tag == tagR[i]) begin
                    dataR[i] <= aluWb.data;
                    tagR[i]  <= tagFree;
                end else if (lsWb.valid && lsWb.name == nameW'(i)
                             && lsWb.tag == tagR[i]) begin
                    dataR[i] <= lsWb.data;
                    tagR[i]  <= tagFree;
                end
            end
        end
    end

    // live tags are unique, so both units cannot return the same one together
    aDistinctWbTags: assert property (@(posedge clk) disable iff (!arstN)
        (aluWb.valid && lsWb.valid && aluWb.tag != tagFree) |-> aluWb.tag != lsWb.tag)
        else $error("both writebacks carry tag %0d", aluWb.tag);

endmodule

// ==== tagCore.sv ====
// host holds instIn steady while waiting for instReady; the inspection port reads any register
module tagCore #(
    parameter int numRegs  = 8,
    parameter int memDepth = 256
) (
    input  logic                     clk,
    input  logic                     arstN,
    input  tagPkg::instr             instIn,
    input  logic                     instValid,
    output logic                     instReady,
    input  logic [tagPkg::nameW-1:0] rdName,
    output logic [tagPkg::dataW-1:0] rdData,
    output logic                     rdBusy
);
    import tagPkg::*;

    // operand reads
    logic [nameW-1:0] nameA;
    logic [nameW-1:0] nameB;
    logic [dataW-1:0] dataA;
    logic [dataW-1:0] dataB;
    logic [tagW-1:0]  tagA;
    logic [tagW-1:0]  tagB;

    // destination tag from dispatch
    logic             decWrtEn;
    logic [nameW-1:0] decWrtName;
    logic [tagW-1:0]  decWrtTag;

    issueBundle aluIssue;
    issueBundle lsIssue;
    wbBundle    aluWb;
    wbBundle    lsWb;

    dispatchUnit u_dispatchUnit (
        .clk        (clk),
        .arstN      (arstN),
        .instIn     (instIn),
        .instValid  (instValid),
        .instReady  (instReady),
        .nameA      (nameA),
        .nameB      (nameB),
        .dataA      (dataA),
        .dataB      (dataB),
        .tagA       (tagA),
        .tagB       (tagB),
        .decWrtEn   (decWrtEn),
        .decWrtName (decWrtName),
        .decWrtTag  (decWrtTag),
        .aluIssue   (aluIssue),
        .lsIssue    (lsIssue)
    );

    aluUnit u_aluUnit (
        .clk      (clk),
        .arstN    (arstN),
        .aluIssue (aluIssue),
        .aluWb    (aluWb)
    );

    loadStoreUnit #(
        .memDepth (memDepth)
    ) u_loadStoreUnit (
        .clk     (clk),
        .arstN   (arstN),
        .lsIssue (lsIssue),
        .lsWb    (lsWb)
    );

    tagRegfile #(
        .numRegs (numRegs)
    ) u_tagRegfile (
        .clk        (clk),
        .arstN      (arstN),
        .aluWb      (aluWb),
        .lsWb       (lsWb),
        .nameA      (nameA),
        .nameB      (nameB),
        .dataA      (dataA),
        .dataB      (dataB),
        .tagA       (tagA),
        .tagB       (tagB),
        .decWrtEn   (decWrtEn),
        .decWrtName (decWrtName),
        .decWrtTag  (decWrtTag),
        .rdName     (rdName),
        .rdData     (rdData),
        .rdBusy     (rdBusy)
    );

endmodule

// ==== tagCoreTb.sv ====
// self-checking testbench; DUT data memory is preloaded by hierarchical reference during reset
module tagCoreTb;
    import tagPkg::*;

    localparam int memDepth = 256;
    localparam int numTests = 6;
    localparam int totalInstr = 13 + 5 + 6 + 3 + 208;
    localparam int cycleLimit = totalInstr * 4 + 100 * numTests;

    logic             clk;
    logic             arstN;
    instr             instIn;
    logic             instValid;
    logic             instReady;
    logic [nameW-1:0] rdName;
    logic [dataW-1:0] rdData;
    logic             rdBusy;

    // sequential model state
    logic [dataW-1:0] modelRegs [8];
    logic [dataW-1:0] modelMem [memDepth];

    logic [31:0] rngState;
    string       testName;
    bit          expectIdle;
    bit          expectStall;
    int          stallCount;
    int          errCount;
    int          testErrStart;
    int          passCount;
    int          failCount;
    int          cycleCount;
    event        checkReq;
    event        checkDone;

    tagCore #(
        .numRegs  (8),
        .memDepth (memDepth)
    ) u_tagCore (
        .clk       (clk),
        .arstN     (arstN),
        .instIn    (instIn),
        .instValid (instValid),
        .instReady (instReady),
        .rdName    (rdName),
        .rdData    (rdData),
        .rdBusy    (rdBusy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // every address bit reaches both bytes
    function automatic logic [dataW-1:0] fillWord(input logic [memAddrW-1:0] a);
        return {a ^ 8'h96, (a * 8'd29) ^ 8'hc3};
    endfunction

    function automatic logic [dataW-1:0] aluRef(input aluFunc f, input logic [dataW-1:0] a,
                                                input logic [dataW-1:0] b);
        case (f)
            aluAdd: return a + b;
            aluSub: return a - b;
            aluAnd: return a & b;
            aluOr: return a | b;
            aluXor: return a ^ b;
            aluShl: return a << b[3:0];
            default: return '0;
        endcase
    endfunction

    // one instruction in program order, address wraps at memDepth
    function automatic void executeRef(input instr i);
        logic [memAddrW-1:0] addr;
        addr = memAddrW'((32'(modelRegs[i.payload.mem.base]) + 32'(i.payload.mem.offset))
                         % memDepth);
        case (i.kind)
            opAlu: modelRegs[i.payload.alu.dest] = aluRef(i.payload.alu.func,
                modelRegs[i.payload.alu.srcA], modelRegs[i.payload.alu.srcB]);
            opLoad: modelRegs[i.payload.mem.dataReg] = modelMem[addr];
            default: modelMem[addr] = modelRegs[i.payload.mem.dataReg];
        endcase
    endfunction

    function automatic instr makeAlu(input aluFunc f, input int d, input int a, input int b);
        instr i;
        i = '0;
        i.kind = opAlu;
        i.payload.alu.dest = nameW'(d);
        i.payload.alu.srcA = nameW'(a);
        i.payload.alu.srcB = nameW'(b);
        i.payload.alu.func = f;
        return i;
    endfunction

    function automatic instr makeMem(input opKind k, input int r, input int base, input int off);
        instr i;
        i = '0;
        i.kind = k;
        i.payload.mem.dataReg = nameW'(r);
        i.payload.mem.base = nameW'(base);
        i.payload.mem.offset = memAddrW'(off);
        return i;
    endfunction

    // holds the instruction until instReady was high before a rising edge
    task automatic sendInstr(input instr i);
        logic ready;
        @(negedge clk);
        instIn = i;
        instValid = 1'b1;
        #1;
        ready = instReady;
        while (!ready) begin
            stallCount++;
            @(negedge clk);
            #1;
            ready = instReady;
        end
        @(posedge clk);
        executeRef(i);
    endtask

    task automatic sendRandom();
        logic [31:0] r;
        rngState = xorshift32(rngState);
        r = rngState;
        case (int'(r % 3))
            0: sendInstr(makeAlu(aluFunc'(r[4:2] % 3'd6), int'(r[7:5]), int'(r[10:8]),
                                 int'(r[13:11])));
            1: sendInstr(makeMem(opLoad, int'(r[7:5]), int'(r[10:8]), int'(r[21:14])));
            default: sendInstr(makeMem(opStore, int'(r[7:5]), int'(r[10:8]), int'(r[21:14])));
        endcase
    endtask

    task automatic startTest(input string name, input bit idle, input bit stall);
        testName = name;
        expectIdle = idle;
        expectStall = stall;
        stallCount = 0;
        testErrStart = errCount;
    endtask

    task automatic runCheck();
        @(negedge clk);
        instValid = 1'b0;
        -> checkReq;
        @(checkDone);
    endtask

    task automatic endTest();
        if (errCount == testErrStart) begin
            passCount++;
            $display("test %s: pass", testName);
        end else begin
            failCount++;
            $display("test %s: fail, %0d errors", testName, errCount - testErrStart);
        end
    endtask

    // compare process: drain, then read every register through the inspection port
    initial begin
        forever begin
            @(checkReq);
            for (int r = 0; r < 8; r++) begin
                @(negedge clk);
                rdName = nameW'(r);
                #1;
                if (expectIdle) begin
                    assert (!rdBusy) else begin
                        $display("FAIL %s r%0d busy expected 0 actual %0b", testName, r,
                                 rdBusy);
                        errCount++;
                    end
                end
                while (rdBusy) begin
                    @(negedge clk);
                    #1;
                end
            end
            for (int r = 0; r < 8; r++) begin
                @(negedge clk);
                rdName = nameW'(r);
                #1;
                assert (rdData == modelRegs[r]) else begin
                    $display("FAIL %s r%0d expected %h actual %h", testName, r,
                             modelRegs[r], rdData);
                    errCount++;
                end
            end
            if (expectStall) begin
                assert (stallCount > 0) else begin
                    $display("test %s: instReady never dropped on a busy source", testName);
                    errCount++;
                end
            end
            -> checkDone;
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: tests still running after %0d cycles", cycleLimit);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        arstN = 1'b0;
        instIn = '0;
        instValid = 1'b0;
        rdName = '0;
        rngState = 32'h70e434e0;
        errCount = 0;
        passCount = 0;
        failCount = 0;
        for (int r = 0; r < 8; r++) begin
            modelRegs[r] = '0;
        end
        @(negedge clk);
        for (int a = 0; a < memDepth; a++) begin
            u_tagCore.u_loadStoreUnit.mem[a] = fillWord(memAddrW'(a));
            modelMem[a] = fillWord(memAddrW'(a));
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        startTest("reset", 1'b1, 1'b0);
        runCheck();
        endTest();

        // operands come from memory first
        startTest("alu functions", 1'b0, 1'b0);
        for (int r = 1; r < 8; r++) begin
            sendInstr(makeMem(opLoad, r, 0, r * 17));
        end
        sendInstr(makeAlu(aluAdd, 0, 1, 2));
        sendInstr(makeAlu(aluSub, 3, 1, 2));
        sendInstr(makeAlu(aluAnd, 4, 2, 1));
        sendInstr(makeAlu(aluOr, 5, 1, 2));
        sendInstr(makeAlu(aluXor, 6, 2, 1));
        sendInstr(makeAlu(aluShl, 7, 1, 2));
        runCheck();
        endTest();

        startTest("dependent chain", 1'b0, 1'b1);
        sendInstr(makeAlu(aluAdd, 1, 1, 2));
        sendInstr(makeAlu(aluXor, 1, 1, 3));
        sendInstr(makeAlu(aluSub, 2, 1, 4));
        sendInstr(makeAlu(aluShl, 3, 2, 1));
        sendInstr(makeAlu(aluAnd, 4, 3, 2));
        runCheck();
        endTest();

        // large offsets wrap past the top of memory
        startTest("store then load", 1'b0, 1'b0);
        sendInstr(makeMem(opStore, 3, 1, 8'h05));
        sendInstr(makeMem(opLoad, 0, 1, 8'h05));
        sendInstr(makeMem(opStore, 4, 2, 8'hff));
        sendInstr(makeMem(opLoad, 5, 2, 8'hff));
        sendInstr(makeMem(opStore, 6, 7, 8'hf0));
        sendInstr(makeMem(opLoad, 1, 7, 8'hf0));
        runCheck();
        endTest();

        startTest("youngest writer", 1'b0, 1'b0);
        sendInstr(makeMem(opLoad, 5, 1, 8'h20));
        sendInstr(makeAlu(aluSub, 5, 2, 3));
        sendInstr(makeAlu(aluAdd, 6, 5, 2));
        runCheck();
        endTest();

        startTest("random program", 1'b0, 1'b0);
        for (int n = 0; n < 200; n++) begin
            sendRandom();
        end
        runCheck();
        // sample memory words into the registers
        for (int r = 0; r < 8; r++) begin
            rngState = xorshift32(rngState);
            sendInstr(makeMem(opLoad, r, int'(rngState[2:0]), int'(rngState[15:8])));
        end
        runCheck();
        endTest();

        $display("tests passed %0d failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
tagPkg.sv
dispatchUnit.sv
aluUnit.sv
loadStoreUnit.sv
tagRegfile.sv
tagCore.sv
tagCoreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tagCoreTb -f sim.f -o simv
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -q "^Finished with no errors$"
